// File: source/policer_pkg.sv
/* Shared widths, vector types and packed structs of the token-bucket policer.
   Used by every RTL module and by the testbench through scoped names */
`default_nettype none

package policer_pkg;

    ////////////////////
    // Sizes

    // Ingress ports with a bucket each
    localparam int num_ports = 4;
    localparam int port_w    = 2;

    // Byte length, wide enough for a 1500 byte MTU
    localparam int len_w     = 11;

    // Bucket arithmetic is 16 whole bits over 8 fraction bits
    localparam int frac_w    = 8;
    localparam int level_w   = 24;

    localparam int prio_w    = 3;

    ////////////////////
    // Vector types

    typedef logic [port_w-1:0]  port_t;
    typedef logic [len_w-1:0]   byte_len_t;
    typedef logic [prio_w-1:0]  prio_t;
    typedef logic [level_w-1:0] level_t;
    typedef logic [level_w-1:0] rate_t;

    // Ceiling of a bucket level
    localparam level_t level_max = '1;

    ////////////////////
    // Descriptors and policy

    typedef struct packed {
        port_t     ingress_port;
        port_t     egress_port;
        prio_t     prio;
        byte_len_t byte_length;
    } pkt_desc_t;

    typedef struct packed {
        pkt_desc_t desc;
        logic      drop_mark;
    } pkt_out_t;

    // Committed rate is the leak per clock, depth is the burst size
    typedef struct packed {
        logic   enable;
        rate_t  rate;
        level_t depth;
    } port_policy_t;

    typedef port_policy_t [num_ports-1:0] policy_table_t;

endpackage

`default_nettype wire

// File: source/desc_pipe.sv
/* One-entry input register for packet descriptors. Also turns the byte
   length into bucket units so the decider only has to add and compare */
`default_nettype none

module desc_pipe (
    input  wire  logic                   core_clk_ifc,
    input  wire  logic                   timer_reset,
    input  wire  policer_pkg::pkt_desc_t in_desc,
    input  wire  logic                   in_valid,
    output logic                         in_ready,
    output policer_pkg::pkt_desc_t       stage_desc,
    output policer_pkg::level_t          stage_len,
    output logic                         stage_valid,
    input  wire  logic                   stage_ready
);

    // Goes high one clock after reset is released
    logic ready_armed;
    logic accept;

    ////////////////////
    // Handshake

    // Free slot, or the current entry leaves this cycle
    assign in_ready = ready_armed && (!stage_valid || stage_ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            ready_armed <= 1'b0;
            stage_valid <= 1'b0;
        end else begin
            ready_armed <= 1'b1;
            if (accept) begin
                stage_valid <= 1'b1;
            end else if (stage_ready) begin
                stage_valid <= 1'b0;
            end
        end
    end

    ////////////////////
    // Payload

    always_ff @(posedge core_clk_ifc) begin
        if (accept) begin
            stage_desc <= in_desc;
            // Whole bytes move above the fraction bits
            stage_len  <= policer_pkg::level_t'(in_desc.byte_length) << policer_pkg::frac_w;
        end
    end

    ////////////////////
    // Checks

    // A stalled entry stays put until the decider takes it
    a_stage_hold : assert property (
        @(posedge core_clk_ifc) disable iff (timer_reset)
        stage_valid && !stage_ready |=> stage_valid && $stable(stage_desc)
            && $stable(stage_len)
    );

endmodule

`default_nettype wire

// File: source/bucket_store.sv
/* Bucket levels of all ingress ports. Each level leaks by its port rate
   every clock, grows on commits and is read back by the mark decider */
`default_nettype none

module bucket_store (
    input  wire  logic                       core_clk_ifc,
    input  wire  logic                       timer_reset,
    input  wire  policer_pkg::policy_table_t policy,
    input  wire  policer_pkg::port_t         query_port,
    output policer_pkg::level_t              query_level,
    input  wire  logic                       commit_valid,
    input  wire  policer_pkg::port_t         commit_port,
    input  wire  policer_pkg::level_t        commit_len
);

    policer_pkg::level_t level_q [policer_pkg::num_ports];
    policer_pkg::level_t level_d [policer_pkg::num_ports];

    ////////////////////
    // Next level

    always_comb begin : next_level
        policer_pkg::level_t             leaked;
        logic [policer_pkg::level_w:0]   fill_sum;
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            // Leak first, floor at an empty bucket
            if (level_q[p] > policy[p].rate) begin
                leaked = level_q[p] - policy[p].rate;
            end else begin
                leaked = '0;
            end

            // Extra top bit catches the overflow
            fill_sum = {1'b0, leaked} + {1'b0, commit_len};

            if (commit_valid && (commit_port == policer_pkg::port_t'(p))) begin
                if (fill_sum[policer_pkg::level_w]) begin
                    level_d[p] = policer_pkg::level_max;
                end else begin
                    level_d[p] = fill_sum[policer_pkg::level_w-1:0];
                end
            end else begin
                level_d[p] = leaked;
            end
        end
    end

    ////////////////////
    // Level registers

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int p = 0; p < policer_pkg::num_ports; p++) begin
                level_q[p] <= '0;
            end
        end else begin
            for (int p = 0; p < policer_pkg::num_ports; p++) begin
                level_q[p] <= level_d[p];
            end
        end
    end

    // Read path for the decider, same cycle
    assign query_level = level_q[query_port];

    ////////////////////
    // Checks

    for (genvar gi = 0; gi < policer_pkg::num_ports; gi++) begin : g_port_chk

        // A commit saturates instead of wrapping past the top
        a_commit_no_wrap : assert property (
            @(posedge core_clk_ifc) disable iff (timer_reset)
            commit_valid && (commit_port == policer_pkg::port_t'(gi))
                |=> level_q[gi] >= $past(commit_len)
        );

        // Without a commit the level can only go down
        a_leak_only : assert property (
            @(posedge core_clk_ifc) disable iff (timer_reset)
            !(commit_valid && (commit_port == policer_pkg::port_t'(gi)))
                |=> level_q[gi] <= $past(level_q[gi])
        );

    end

endmodule

`default_nettype wire

// File: source/mark_decider.sv
/* Decides the drop mark of each staged descriptor against its port bucket.
   Commits conforming lengths and holds the output register under valid/ready */
`default_nettype none

module mark_decider (
    input  wire  logic                       core_clk_ifc,
    input  wire  logic                       timer_reset,
    input  wire  policer_pkg::policy_table_t policy,
    input  wire  policer_pkg::pkt_desc_t     stage_desc,
    input  wire  policer_pkg::level_t        stage_len,
    input  wire  logic                       stage_valid,
    output logic                             stage_ready,
    output policer_pkg::port_t               query_port,
    input  wire  policer_pkg::level_t        query_level,
    output logic                             commit_valid,
    output policer_pkg::port_t               commit_port,
    output policer_pkg::level_t              commit_len,
    output policer_pkg::pkt_out_t            out_pkt,
    output logic                             out_valid,
    input  wire  logic                       out_ready
);

    policer_pkg::port_policy_t     port_pol;
    logic [policer_pkg::level_w:0] fill_sum;
    logic                          over_depth;
    logic                          drop_mark;
    logic                          take;

    ////////////////////
    // Mark decision

    // Bucket and policy of the staged packet's ingress port
    assign query_port = stage_desc.ingress_port;
    assign port_pol   = policy[stage_desc.ingress_port];

    // One extra bit so a full bucket plus a packet cannot wrap
    assign fill_sum   = {1'b0, stage_len} + {1'b0, query_level};
    assign over_depth = fill_sum > {1'b0, port_pol.depth};

    // Disabled ports never mark
    assign drop_mark  = port_pol.enable && over_depth;

    ////////////////////
    // Handshake and commit

    assign stage_ready = !out_valid || out_ready;
    assign take        = stage_valid && stage_ready;

    // Bucket picks this up on the same edge that loads out_pkt
    assign commit_valid = take && port_pol.enable && !drop_mark;
    assign commit_port  = stage_desc.ingress_port;
    assign commit_len   = stage_len;

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (take) begin
            out_pkt.desc      <= stage_desc;
            out_pkt.drop_mark <= drop_mark;
        end
    end

    ////////////////////
    // Checks

    // Whatever filled a bucket must leave unmarked
    a_commit_unmarked : assert property (
        @(posedge core_clk_ifc) disable iff (timer_reset)
        commit_valid |=> out_valid && !out_pkt.drop_mark
    );

    // Output holds while the sink stalls
    a_out_hold : assert property (
        @(posedge core_clk_ifc) disable iff (timer_reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pkt)
    );

endmodule

`default_nettype wire

// File: source/policer_top.sv
/* Top level of the per-ingress-port policer. Takes packet descriptors under
   valid/ready and returns them with a drop mark added */
`default_nettype none

module policer_top (
    input  wire  logic                       core_clk_ifc,
    input  wire  logic                       timer_reset,
    input  wire  policer_pkg::policy_table_t policy,
    input  wire  policer_pkg::pkt_desc_t     in_desc,
    input  wire  logic                       in_valid,
    output logic                             in_ready,
    output policer_pkg::pkt_out_t            out_pkt,
    output logic                             out_valid,
    input  wire  logic                       out_ready
);

    // Input stage to decider
    policer_pkg::pkt_desc_t stage_desc;
    policer_pkg::level_t    stage_len;
    logic                   stage_valid;
    logic                   stage_ready;

    // Decider and bucket store
    policer_pkg::port_t     query_port;
    policer_pkg::level_t    query_level;
    logic                   commit_valid;
    policer_pkg::port_t     commit_port;
    policer_pkg::level_t    commit_len;

    desc_pipe desc_pipe0 (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .in_desc      (in_desc),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .stage_desc   (stage_desc),
        .stage_len    (stage_len),
        .stage_valid  (stage_valid),
        .stage_ready  (stage_ready)
    );

    bucket_store bucket_store0 (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .policy       (policy),
        .query_port   (query_port),
        .query_level  (query_level),
        .commit_valid (commit_valid),
        .commit_port  (commit_port),
        .commit_len   (commit_len)
    );

    mark_decider mark_decider0 (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .policy       (policy),
        .stage_desc   (stage_desc),
        .stage_len    (stage_len),
        .stage_valid  (stage_valid),
        .stage_ready  (stage_ready),
        .query_port   (query_port),
        .query_level  (query_level),
        .commit_valid (commit_valid),
        .commit_port  (commit_port),
        .commit_len   (commit_len),
        .out_pkt      (out_pkt),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

// File: include/policer_tb_model.svh
/* LFSR and reference policer model, included inside the testbench module.
   The model tracks whole-byte levels and queues the expected outputs */
`ifndef POLICER_TB_MODEL_SVH
`define POLICER_TB_MODEL_SVH

// Expected bucket levels in whole bytes, and the expected output order
int unsigned           model_level [policer_pkg::num_ports];
policer_pkg::pkt_out_t model_q [$];

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
endfunction

// One step per bit taken, low bit first
function automatic int unsigned lfsr_take(inout logic [31:0] state, input int nbits);
    int unsigned value;
    value = 0;
    for (int b = 0; b < nbits; b++) begin
        state = lfsr_next(state);
        value = value | (int'(state[0]) << b);
    end
    return value;
endfunction

function automatic void model_clear();
    foreach (model_level[p]) begin
        model_level[p] = 0;
    end
    model_q.delete();
endfunction

// Expects a zero rate, so the level only moves on commits
function automatic void model_push(input policer_pkg::pkt_desc_t desc,
                                   input policer_pkg::port_policy_t pol);
    policer_pkg::pkt_out_t exp_pkt;
    int unsigned           depth_bytes;
    depth_bytes       = int'(pol.depth >> policer_pkg::frac_w);
    exp_pkt.desc      = desc;
    exp_pkt.drop_mark = 1'b0;
    if (pol.enable) begin
        if (desc.byte_length + model_level[desc.ingress_port] > depth_bytes) begin
            exp_pkt.drop_mark = 1'b1;
        end else begin
            model_level[desc.ingress_port] += desc.byte_length;
        end
    end
    model_q.push_back(exp_pkt);
endfunction

// Clocks for a level to leak from one byte count down to another, rounded up
function automatic longint model_drain_cycles(input int unsigned from_bytes,
                                              input int unsigned to_bytes,
                                              input policer_pkg::rate_t rate);
    longint drop_fixed;
    drop_fixed = longint'(from_bytes - to_bytes) << policer_pkg::frac_w;
    return (drop_fixed + longint'(rate) - 1) / longint'(rate);
endfunction

`endif

// File: dv/policer_tb.sv
/* Testbench for the policer top level. Sends random descriptors and checks
   each output transfer against the reference model with assertions */
`default_nettype none

module policer_tb;

    localparam int wait_limit = 50000;

    logic                       core_clk_ifc;
    logic                       timer_reset;
    policer_pkg::policy_table_t policy;
    policer_pkg::pkt_desc_t     in_desc;
    logic                       in_valid;
    logic                       in_ready;
    policer_pkg::pkt_out_t      out_pkt;
    logic                       out_valid;
    logic                       out_ready;

    logic [31:0]           lfsr_state;
    logic                  bp_on;
    logic                  in_taken    = 1'b0;
    logic                  front_valid = 1'b0;
    policer_pkg::pkt_out_t exp_front   = '0;
    longint                cycle_cnt   = 0;
    string                 test_name;
    int                    errors;
    int                    checks;
    int                    base_errors;
    int                    sent;

    `include "policer_tb_model.svh"

    policer_top dut0 (.*);

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    ////////////////////
    // Output tracking

    always @(posedge core_clk_ifc) begin
        cycle_cnt <= cycle_cnt + 1;
        in_taken  <= !timer_reset && in_valid && in_ready;
        if (!timer_reset && out_valid && out_ready) begin
            checks++;
            if (model_q.size() > 0) begin
                void'(model_q.pop_front());
            end
        end
        // Front of the expected queue for the next edge
        front_valid <= model_q.size() > 0;
        if (model_q.size() > 0) begin
            exp_front <= model_q[0];
        end
    end

    a_out_matches : assert property (
        @(posedge core_clk_ifc) disable iff (timer_reset)
        out_valid && out_ready && front_valid |-> out_pkt == exp_front
    ) else begin
        errors++;
        $display("ERROR %s: expected %h actual %h", test_name,
                 $sampled(exp_front), $sampled(out_pkt));
    end

    a_out_expected : assert property (
        @(posedge core_clk_ifc) disable iff (timer_reset)
        out_valid && out_ready |-> front_valid
    ) else begin
        errors++;
        $display("%s: the DUT sent a packet that the model does not expect", test_name);
    end

    a_out_held : assert property (
        @(posedge core_clk_ifc) disable iff (timer_reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pkt)
    ) else begin
        errors++;
        $display("%s: the output changed while the sink was stalling", test_name);
    end

    // Input opens one cycle after reset, with the output empty
    a_ready_after_reset : assert property (
        @(posedge core_clk_ifc)
        $fell(timer_reset) |-> !in_ready && !out_valid ##1 in_ready
    ) else begin
        errors++;
        $display("%s: in_ready or out_valid was wrong right after reset", test_name);
    end

    ////////////////////
    // Helpers

    task automatic abort_run(input string reason);
        errors++;
        $display("%s: %s", test_name, reason);
        $display("Errors found");
        $finish;
    endtask

    // Length from 64 to 1500 bytes
    function automatic policer_pkg::pkt_desc_t random_desc();
        policer_pkg::pkt_desc_t d;
        d.ingress_port = policer_pkg::port_t'(lfsr_take(lfsr_state, policer_pkg::port_w));
        d.egress_port  = policer_pkg::port_t'(lfsr_take(lfsr_state, policer_pkg::port_w));
        d.prio         = policer_pkg::prio_t'(lfsr_take(lfsr_state, policer_pkg::prio_w));
        d.byte_length  = policer_pkg::byte_len_t'(
            64 + lfsr_take(lfsr_state, policer_pkg::len_w) % 1437);
        return d;
    endfunction

    // Offer one descriptor, then queue its expected output once taken
    task automatic send(input policer_pkg::pkt_desc_t d, input logic modeled,
                        input logic mark);
        int                    waited;
        policer_pkg::pkt_out_t exp_pkt;
        in_desc  = d;
        in_valid = 1'b1;
        waited   = 0;
        do begin
            @(negedge core_clk_ifc);
            waited++;
            if (bp_on) begin
                out_ready = lfsr_take(lfsr_state, 1) != 0;
            end
        end while (!in_taken && waited < wait_limit);
        if (!in_taken) begin
            abort_run("the DUT never accepted a descriptor");
        end else begin
            sent++;
            if (modeled) begin
                model_push(d, policy[d.ingress_port]);
            end else begin
                exp_pkt.desc      = d;
                exp_pkt.drop_mark = mark;
                model_q.push_back(exp_pkt);
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        in_valid = 1'b0;
        waited   = 0;
        while ((model_q.size() > 0 || out_valid) && waited < wait_limit) begin
            @(negedge core_clk_ifc);
            waited++;
            if (bp_on) begin
                out_ready = lfsr_take(lfsr_state, 1) != 0;
            end
        end
        if (model_q.size() > 0 || out_valid) begin
            abort_run("expected packets never left the DUT");
        end else begin
            out_ready = 1'b1;
        end
    endtask

    task automatic wait_cycle(input longint target);
        int waited;
        waited = 0;
        while (cycle_cnt < target && waited < wait_limit) begin
            @(negedge core_clk_ifc);
            waited++;
        end
        if (cycle_cnt < target) begin
            abort_run("the leak wait ran past its limit");
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        base_errors = errors;
        sent        = 0;
        bp_on       = 1'b0;
        out_ready   = 1'b1;
        in_valid    = 1'b0;
        timer_reset = 1'b1;
        repeat (4) @(negedge core_clk_ifc);
        timer_reset = 1'b0;
        model_clear();
    endtask

    task automatic end_test();
        wait_drained();
        $display("%s: %0d packets sent, %0d errors", test_name, sent, errors - base_errors);
    endtask

    ////////////////////
    // Tests

    initial begin
        policer_pkg::pkt_desc_t d;
        longint                 t_fill;
        timer_reset = 1'b1;
        policy      = '0;
        in_desc     = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b1;
        bp_on       = 1'b0;
        lfsr_state  = 32'd92;
        errors      = 0;
        checks      = 0;
        test_name   = "startup";

        begin_test("drop_all");
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            policy[p] = '{enable: 1'b1, rate: '0, depth: '0};
        end
        for (int i = 0; i < 20; i++) begin
            send(random_desc(), 1'b1, 1'b0);
        end
        end_test();

        begin_test("accept_all");
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            policy[p] = '{enable: 1'b1, rate: '1, depth: '1};
        end
        for (int i = 0; i < 20; i++) begin
            send(random_desc(), 1'b1, 1'b0);
        end
        end_test();

        // Random stalls on the output during the burst test
        begin_test("burst_backpressure");
        bp_on = 1'b1;
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            policy[p] = '{enable: 1'b1, rate: '0,
                          depth: policer_pkg::level_t'(lfsr_take(lfsr_state, 12)) << 8};
        end
        for (int i = 0; i < 48; i++) begin
            send(random_desc(), 1'b1, 1'b0);
        end
        end_test();

        begin_test("leak_rate");
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            policy[p] = '{enable: 1'b1,
                          rate:   policer_pkg::rate_t'(16 + lfsr_take(lfsr_state, 8)),
                          depth:  policer_pkg::level_t'(1000 << policer_pkg::frac_w)};
        end
        d             = random_desc();
        d.byte_length = 11'd1000;
        send(d, 1'b0, 1'b0);
        t_fill = cycle_cnt;
        wait_drained();
        // Roughly 8 bytes still in the bucket, so a full-depth packet overflows
        wait_cycle(t_fill + model_drain_cycles(1000, 8, policy[d.ingress_port].rate));
        send(d, 1'b0, 1'b1);
        wait_drained();
        wait_cycle(t_fill + model_drain_cycles(1000, 0, policy[d.ingress_port].rate) + 4);
        send(d, 1'b0, 1'b0);
        end_test();

        begin_test("disable");
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            policy[p] = '{enable: lfsr_take(lfsr_state, 1) != 0, rate: '0, depth: '0};
        end
        for (int i = 0; i < 24; i++) begin
            send(random_desc(), 1'b1, 1'b0);
        end
        end_test();

        $display("5 tests, %0d outputs checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
source/policer_pkg.sv
source/desc_pipe.sv
source/bucket_store.sv
source/mark_decider.sv
source/policer_top.sv
dv/policer_tb.sv

// File: Makefile
SIM      := verilator
FLIST    := flist.f
TOP      := policer_tb
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := No errors

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
